// File: design/wm_settings.svh
`ifndef WM_SETTINGS_SVH
`define WM_SETTINGS_SVH

// Number of lanes.
`define WM_WIDTH 16

// Weights held per lane.
`define WM_DEPTH 8

// Bits per signed weight.
`define WM_BITWIDTH 8

`endif

// File: design/wm_types_pkg.sv
`include "wm_settings.svh"

package wm_types_pkg;

    // One signed weight.
    typedef logic signed [`WM_BITWIDTH-1:0] weight_t;

    // Per-lane increment, -2 to +1.
    typedef logic signed [1:0] step_t;

    typedef logic [$clog2(`WM_WIDTH)-1:0] lane_idx_t;
    typedef logic [$clog2(`WM_DEPTH)-1:0] depth_idx_t;

    // Load value in the low bits, or one 2-bit step per lane.
    typedef logic [2*`WM_WIDTH-1:0] data_word_t;

    // One lane's column and the full array.
    typedef weight_t [`WM_DEPTH-1:0] lane_weights_t;
    typedef lane_weights_t [`WM_WIDTH-1:0] weight_bank_t;

endpackage

// File: design/wm_instr_pkg.sv
package wm_instr_pkg;

    typedef enum logic {
        OP_LOAD      = 1'b0,
        OP_INCREMENT = 1'b1
    } wm_op_e;

    // Same bit order as the instruction word: op on top, depth at the bottom.
    typedef struct packed {
        wm_op_e                   op;
        wm_types_pkg::lane_idx_t  lane;
        wm_types_pkg::depth_idx_t depth;
    } wm_instr_t;

    typedef struct packed {
        logic                     valid;
        wm_op_e                   op;
        wm_types_pkg::lane_idx_t  lane;
        wm_types_pkg::depth_idx_t depth;
        wm_types_pkg::data_word_t data;
    } wm_cmd_t;

    typedef enum logic {
        DEC_IDLE,
        DEC_HELD
    } wm_dec_state_e;

endpackage

// File: design/wm_decoder.sv
`timescale 1ns/1ps

module wm_decoder (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     exec,
    input  wm_instr_pkg::wm_instr_t  inst,
    input  wm_types_pkg::data_word_t data,
    output wm_instr_pkg::wm_cmd_t    cmd
);

    wm_instr_pkg::wm_dec_state_e state;
    wm_instr_pkg::wm_dec_state_e state_next;
    logic                        issue;
    logic                        cmd_valid;
    wm_instr_pkg::wm_instr_t     inst_q;
    wm_types_pkg::data_word_t    data_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Exec edge detection.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        state_next = state;
        issue      = 1'b0;
        case (state)
            wm_instr_pkg::DEC_IDLE: begin
                if (exec) begin
                    issue      = 1'b1;
                    state_next = wm_instr_pkg::DEC_HELD;
                end
            end
            wm_instr_pkg::DEC_HELD: begin
                if (!exec) begin
                    state_next = wm_instr_pkg::DEC_IDLE;
                end
            end
            default: state_next = wm_instr_pkg::DEC_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= wm_instr_pkg::DEC_IDLE;
            cmd_valid <= 1'b0;
        end else begin
            state     <= state_next;
            cmd_valid <= issue;
        end
    end

    // Payload is captured with the pulse so lanes see it stable.
    always_ff @(posedge clk) begin
        if (issue) begin
            inst_q <= inst;
            data_q <= data;
        end
    end

    assign cmd.valid = cmd_valid;
    assign cmd.op    = inst_q.op;
    assign cmd.lane  = inst_q.lane;
    assign cmd.depth = inst_q.depth;
    assign cmd.data  = data_q;

    // One exec rise gives a single-cycle command.
    a_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) cmd.valid |=> !cmd.valid
    );

endmodule

// File: design/wm_lane.sv
`timescale 1ns/1ps
`include "wm_settings.svh"

module wm_lane (
    input  logic                        clk,
    input  logic                        rst_n,
    input  wm_types_pkg::lane_idx_t     lane,
    input  wm_instr_pkg::wm_cmd_t       cmd,
    output wm_types_pkg::lane_weights_t column
);

    wm_types_pkg::step_t   step;
    wm_types_pkg::weight_t load_value;
    wm_types_pkg::weight_t cur_weight;
    wm_types_pkg::weight_t next_weight;
    logic                  is_load;
    logic                  is_inc;
    logic                  write_en;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Command decode for this lane.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Bits 2i+1..2i of the data word hold lane i's step.
    assign step       = cmd.data[{lane, 1'b0} +: 2];
    assign load_value = cmd.data[`WM_BITWIDTH-1:0];
    assign cur_weight = column[cmd.depth];

    assign is_load  = cmd.valid && (cmd.op == wm_instr_pkg::OP_LOAD) && (cmd.lane == lane);
    assign is_inc   = cmd.valid && (cmd.op == wm_instr_pkg::OP_INCREMENT);
    assign write_en = is_load || is_inc;

    // Two's complement wrap, no saturation.
    always_comb begin
        if (is_load) begin
            next_weight = load_value;
        end else begin
            next_weight = cur_weight + wm_types_pkg::weight_t'(step);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Weight storage.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int d = 0; d < `WM_DEPTH; d++) begin
                column[d] <= '0;
            end
        end else if (write_en) begin
            column[cmd.depth] <= next_weight;
        end
    end

    // A load to this lane is visible on the next cycle.
    a_load_lands: assert property (
        @(posedge clk) disable iff (!rst_n)
        is_load |=> column[$past(cmd.depth)] == $past(load_value)
    );

endmodule

// File: design/wm_read_port.sv
`timescale 1ns/1ps

module wm_read_port (
    input  logic                       clk,
    input  logic                       rst_n,
    input  wm_types_pkg::weight_bank_t bank,
    input  wm_types_pkg::lane_idx_t    lane,
    input  wm_types_pkg::depth_idx_t   depth,
    output wm_types_pkg::weight_t      read_reg
);

    wm_types_pkg::weight_t selected;

    // Select from the bank as it stands before the edge.
    assign selected = bank[lane][depth];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            read_reg <= '0;
        end else begin
            read_reg <= selected;
        end
    end

    a_read_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(read_reg)
    );

endmodule

// File: design/weight_manager.sv
`timescale 1ns/1ps
`include "wm_settings.svh"

module weight_manager (
    input  logic                       clk,
    input  logic                       rst_n,
    input  wm_instr_pkg::wm_instr_t    inst,
    input  wm_types_pkg::data_word_t   data,
    input  logic                       exec,
    output wm_types_pkg::weight_t      read_reg,
    output wm_types_pkg::weight_bank_t weights
);

    wm_instr_pkg::wm_cmd_t cmd;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Command path.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    wm_decoder u_decoder (
        .clk   (clk),
        .rst_n (rst_n),
        .exec  (exec),
        .inst  (inst),
        .data  (data),
        .cmd   (cmd)
    );

    // Every lane sees the same command.
    for (genvar g = 0; g < `WM_WIDTH; g++) begin : g_lane
        wm_lane u_lane (
            .clk    (clk),
            .rst_n  (rst_n),
            .lane   (wm_types_pkg::lane_idx_t'(g)),
            .cmd    (cmd),
            .column (weights[g])
        );
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read path.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    wm_read_port u_read_port (
        .clk      (clk),
        .rst_n    (rst_n),
        .bank     (weights),
        .lane     (inst.lane),
        .depth    (inst.depth),
        .read_reg (read_reg)
    );

endmodule

// File: sim/wm_tb.sv
`timescale 1ns/1ps
`include "wm_settings.svh"

module wm_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int LOAD_CYCLES  = `WM_WIDTH * `WM_DEPTH * 3;
    localparam int INC_CYCLES   = `WM_DEPTH * 2;
    localparam int HOLD_CYCLES  = 10;
    localparam int WRAP_CYCLES  = 12;
    localparam int TOTAL_CYCLES = RESET_CYCLES + LOAD_CYCLES + INC_CYCLES
                                  + HOLD_CYCLES + WRAP_CYCLES;

    logic                       clk;
    logic                       rst_n;
    wm_instr_pkg::wm_instr_t    inst;
    wm_types_pkg::data_word_t   data;
    logic                       exec;
    wm_types_pkg::weight_t      read_reg;
    wm_types_pkg::weight_bank_t weights;

    wm_types_pkg::weight_bank_t model;
    logic [31:0]                lfsr;

    weight_manager DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .inst     (inst),
        .data     (data),
        .exec     (exec),
        .read_reg (read_reg),
        .weights  (weights)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD * 2);
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    // Expected weight after one command, wrapping in two's complement.
    function automatic wm_types_pkg::weight_t expected_weight(
        input wm_types_pkg::weight_t    old,
        input wm_instr_pkg::wm_op_e     op,
        input bit                       addressed,
        input int                       lane,
        input wm_types_pkg::data_word_t word
    );
        wm_types_pkg::step_t step;
        int                  sum;
        if (op == wm_instr_pkg::OP_LOAD) begin
            if (addressed) begin
                return wm_types_pkg::weight_t'(word[`WM_BITWIDTH-1:0]);
            end
            return old;
        end
        step = word[2*lane +: 2];
        sum  = int'(old) + int'(step);
        return wm_types_pkg::weight_t'(sum);
    endfunction

    task automatic apply_to_model(
        input wm_instr_pkg::wm_op_e     op,
        input int                       lane,
        input int                       depth,
        input wm_types_pkg::data_word_t word
    );
        for (int l = 0; l < `WM_WIDTH; l++) begin
            model[l][depth] = expected_weight(model[l][depth], op, l == lane, l, word);
        end
    endtask

    task automatic check_value(
        input string                 name,
        input wm_types_pkg::weight_t actual,
        input wm_types_pkg::weight_t expected
    );
        if (actual !== expected) begin
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, actual,
                     expected);
            $display("Simulation failed");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic check_bank();
        for (int l = 0; l < `WM_WIDTH; l++) begin
            for (int d = 0; d < `WM_DEPTH; d++) begin
                check_value($sformatf("weights[%0d][%0d]", l, d), weights[l][d], model[l][d]);
            end
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // Exec high for hold cycles; the update lands one edge after the first sample.
    task automatic run_command(
        input wm_instr_pkg::wm_op_e     op,
        input int                       lane,
        input int                       depth,
        input wm_types_pkg::data_word_t word,
        input int                       hold
    );
        inst.op    = op;
        inst.lane  = wm_types_pkg::lane_idx_t'(lane);
        inst.depth = wm_types_pkg::depth_idx_t'(depth);
        data       = word;
        exec       = 1'b1;
        repeat (hold) next_cycle();
        exec = 1'b0;
        next_cycle();
        apply_to_model(op, lane, depth, word);
    endtask

    task automatic read_back(input int lane, input int depth);
        inst.lane  = wm_types_pkg::lane_idx_t'(lane);
        inst.depth = wm_types_pkg::depth_idx_t'(depth);
        next_cycle();
        check_value($sformatf("read_reg[%0d][%0d]", lane, depth), read_reg, model[lane][depth]);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic [31:0]           r;
        wm_types_pkg::weight_t got;

        lfsr  = 32'h106c;
        model = '0;
        rst_n = 1'b0;
        exec  = 1'b0;
        inst  = '0;
        data  = '0;

        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_value("read_reg", read_reg, 0);
        check_bank();

        // Random load into every lane and depth.
        for (int l = 0; l < `WM_WIDTH; l++) begin
            for (int d = 0; d < `WM_DEPTH; d++) begin
                random_bits(32, r);
                run_command(wm_instr_pkg::OP_LOAD, l, d, r, 1);
            end
        end
        check_bank();
        for (int l = 0; l < `WM_WIDTH; l++) begin
            for (int d = 0; d < `WM_DEPTH; d++) begin
                read_back(l, d);
            end
        end

        // One increment per depth, random steps.
        for (int d = 0; d < `WM_DEPTH; d++) begin
            random_bits(32, r);
            run_command(wm_instr_pkg::OP_INCREMENT, int'(r[3:0]), d, r, 1);
            check_bank();
        end

        // Exec held high; lane 0 steps by +1 so a double update shows.
        random_bits(32, r);
        r[1:0] = 2'b01;
        run_command(wm_instr_pkg::OP_INCREMENT, 0, 3, r, 5);
        check_bank();
        next_cycle();
        next_cycle();
        check_bank();

        // Wrap at both ends.
        run_command(wm_instr_pkg::OP_LOAD, 0, 2, 32'h0000_007f, 1);
        run_command(wm_instr_pkg::OP_LOAD, 1, 2, 32'h0000_0080, 1);
        run_command(wm_instr_pkg::OP_INCREMENT, 0, 2, 32'h0000_0009, 1);
        check_bank();
        got = weights[0][2];
        check_value("weights[0][2]", got, wm_types_pkg::weight_t'(-128));
        got = weights[1][2];
        check_value("weights[1][2]", got, 126);
        read_back(0, 2);
        read_back(1, 2);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: build.f
+incdir+design
design/wm_types_pkg.sv
design/wm_instr_pkg.sv
design/wm_decoder.sv
design/wm_lane.sv
design/wm_read_port.sv
design/weight_manager.sv
sim/wm_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f build.f --top-module wm_tb -Mdir obj_dir -o wm_sim

./obj_dir/wm_sim | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    exit 0
else
    echo "pass message not found in sim.log"
    exit 1
fi
